// ==== Makefile ====
SOURCES = $(wildcard verilog/*.sv testbench/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_scalar_pipeline
	./obj_dir/Vtb_scalar_pipeline | tee /dev/stderr | grep -F '** PASS **' > /dev/null

obj_dir/Vtb_scalar_pipeline: list.f $(SOURCES)
	verilator --binary --assert --top-module tb_scalar_pipeline -f list.f

clean:
	rm -rf obj_dir

// ==== list.f ====
verilog/cpu_pkg.sv
verilog/pipe_if.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/scalar_pipeline.sv
testbench/pipeline_properties.sv
testbench/tb_scalar_pipeline.sv

// ==== testbench/pipeline_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_properties import cpu_pkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     inst_valid,
  input logic     wb_valid,
  input reg_idx_t wb_reg
);

  // register 0 never shows up on writeback
  a_wb_reg_nonzero: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> wb_reg != '0)
    else $error("writeback names register 0");

  // four stages from the instruction port to writeback
  a_wb_after_inst: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> $past(inst_valid, 4))
    else $error("writeback without an instruction four cycles earlier");

  a_wb_quiet_in_reset: assert property (@(posedge clk)
    reset |=> !wb_valid)
    else $error("writeback during or right after reset");

endmodule

bind scalar_pipeline pipeline_properties u_pipeline_properties (
  .clk        (clk),
  .reset      (reset),
  .inst_valid (inst_valid),
  .wb_valid   (wb_valid),
  .wb_reg     (wb_reg)
);

`default_nettype wire

// ==== testbench/program_input.txt ====
# instruction(hex) expect_wb reg(dec) data(hex) name
# expect_wb 0 means no writeback, reg and data are then ignored
20011234 1 1 00001234 addi_r1
20028001 1 2 00008001 addi_r2_zext
20230100 1 3 00001334 addi_r3
2044ffff 1 4 00018000 addi_r4_zext
04222800 1 5 00009235 add_r5
08a33000 1 6 00007f01 sub_r6
0cc53800 1 7 00001201 and_r7
10e44000 1 8 00019201 or_r8
08224800 1 9 ffff9233 sub_r9_wrap
28280015 0 0 00000000 sw_r8_idx9
246a0055 1 10 00019201 lw_r10_idx9
244b0008 1 11 00019201 lw_r11_idx9
05616000 1 12 0001a435 add_after_lw
28890003 0 0 00000000 sw_r9_idx3
240d0043 1 13 ffff9233 lw_r13_idx3
11a07000 1 14 ffff9233 or_after_lw
20200055 0 0 00000000 addi_to_r0
04220000 0 0 00000000 add_to_r0
fc221800 0 0 00000000 undefined_op63
14a53000 0 0 00000000 undefined_op5
00000000 0 0 00000000 nop
04037800 1 15 00001334 add_r0_r3
10008000 1 16 00000000 or_r0_r0
22310001 1 17 00000001 addi_r17_a
22310002 1 17 00000003 addi_r17_b
06318800 1 17 00000006 add_r17_r17
0a2f9000 1 18 ffffecd2 sub_r18

// ==== testbench/tb_scalar_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_scalar_pipeline import cpu_pkg::*; ();

  logic     clk = 1'b0;
  logic     reset;
  logic     inst_valid;
  word_t    inst;
  logic     wb_valid;
  reg_idx_t wb_reg;
  word_t    wb_data;

  // program as read from the data file
  word_t    prog_inst [$];
  logic     prog_flag [$];
  reg_idx_t prog_reg [$];
  word_t    prog_data [$];
  string    prog_name [$];

  // expectations in flight, oldest first
  int       due_cycle [$];
  logic     due_flag [$];
  reg_idx_t due_reg [$];
  word_t    due_data [$];
  string    due_name [$];

  int          cycle = 0;
  int          cycle_limit = 50;
  int          checked = 0;
  int unsigned lcg_state = 32'd51117;

  scalar_pipeline u_scalar_pipeline (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

  always #4 clk = ~clk;

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_valid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_run($sformatf("[FAIL] %s wb_valid expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t expected, input reg_idx_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("[FAIL] %s wb_reg expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("[FAIL] %s wb_data expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic read_program();
    int    fd;
    int    n;
    int    flag;
    int    idx;
    string line;
    string name;
    word_t word;
    word_t data;
    fd = $fopen("testbench/program_input.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open testbench/program_input.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%h %d %d %h %s", word, flag, idx, data, name);
          if (n == 5) begin
            prog_inst.push_back(word);
            prog_flag.push_back(flag != 0);
            prog_reg.push_back(reg_idx_t'(idx));
            prog_data.push_back(data);
            prog_name.push_back(name);
          end
        end
      end
      $fclose(fd);
      if (prog_inst.size() == 0) begin
        stop_run("the data file holds no instructions");
      end
    end
  endtask

  ////////////////////////////////////////
  // writeback checker, mid cycle

  always @(negedge clk) begin
    cycle = cycle + 1;
    if (due_cycle.size() > 0 && due_cycle[0] == cycle) begin
      check_valid(due_name[0], due_flag[0], wb_valid);
      if (due_flag[0]) begin
        check_reg(due_name[0], due_reg[0], wb_reg);
        check_word(due_name[0], due_data[0], wb_data);
      end
      due_cycle.delete(0);
      due_flag.delete(0);
      due_reg.delete(0);
      due_data.delete(0);
      due_name.delete(0);
      checked = checked + 1;
    end else if (wb_valid === 1'b1) begin
      stop_run($sformatf("unexpected writeback to register %0d at cycle %0d with nothing due",
                         wb_reg, cycle));
    end
    if (cycle > cycle_limit) begin
      stop_run($sformatf("timeout after %0d cycles with %0d results checked", cycle, checked));
    end
  end

  ////////////////////////////////////////
  // stimulus

  initial begin
    int unsigned gap;
    reset      <= 1'b1;
    inst_valid <= 1'b0;
    inst       <= '0;
    read_program();
    cycle_limit = prog_inst.size() * 8 + 50;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    foreach (prog_inst[i]) begin
      lcg_state = lcg_next(lcg_state);
      gap = (lcg_state >> 16) % 4;
      // bubbles carry junk words that must be ignored
      repeat (gap) begin
        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= lcg_state;
      end
      @(posedge clk);
      inst_valid <= 1'b1;
      inst       <= prog_inst[i];
      // sent in the coming cycle, result four cycles later
      due_cycle.push_back(cycle + 1 + 4);
      due_flag.push_back(prog_flag[i]);
      due_reg.push_back(prog_reg[i]);
      due_data.push_back(prog_data[i]);
      due_name.push_back(prog_name[i]);
    end
    @(posedge clk);
    inst_valid <= 1'b0;
    inst       <= '0;
    while (checked < prog_inst.size()) begin
      @(posedge clk);
    end
    // a few quiet cycles to catch a stray writeback
    repeat (4) @(posedge clk);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam int num_regs  = 32;
  localparam int ram_words = 64;

  // instruction field positions
  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_lsb     = 21;
  localparam int rt_lsb     = 16;
  localparam int rd_lsb     = 11;
  localparam int imm_width  = 16;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [$clog2(ram_words)-1:0] ram_addr_t;
  typedef logic [imm_width-1:0] imm_t;

  typedef enum logic [5:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_addi = 6'd8,
    op_lw   = 6'd9,
    op_sw   = 6'd10
  } opcode_t;

  typedef enum logic [1:0] {alu_add, alu_sub, alu_and, alu_or} alu_op_t;

  typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_op_t;

  // operand source in execute
  typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_t;

endpackage

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     inst_valid,
  input  word_t    inst,
  input  logic     wb_valid,
  input  reg_idx_t wb_reg,
  input  word_t    wb_data,
  ex_bus.source    ex
);

  logic     ir_valid;
  word_t    ir_inst;
  opcode_t  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  imm_t     imm;
  alu_op_t  alu_op;
  mem_op_t  mem_op;
  logic     reg_write;
  logic     use_imm;
  reg_idx_t dest;
  word_t    read_a;
  word_t    read_b;

  ////////////////////////////////////////
  // instruction register

  always_ff @(posedge clk) begin
    if (reset) begin
      ir_valid <= 1'b0;
    end else begin
      ir_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    ir_inst <= inst;
  end

  assign opcode = opcode_t'(ir_inst[opcode_msb:opcode_lsb]);
  assign rs     = ir_inst[rs_lsb +: $bits(reg_idx_t)];
  assign rt     = ir_inst[rt_lsb +: $bits(reg_idx_t)];
  assign rd     = ir_inst[rd_lsb +: $bits(reg_idx_t)];
  assign imm    = ir_inst[imm_width-1:0];

  ////////////////////////////////////////
  // control decode

  always_comb begin
    alu_op    = alu_add;
    mem_op    = mem_none;
    reg_write = 1'b0;
    use_imm   = 1'b0;
    dest      = rd;
    case (opcode)
      op_add: reg_write = 1'b1;
      op_sub: begin
        alu_op    = alu_sub;
        reg_write = 1'b1;
      end
      op_and: begin
        alu_op    = alu_and;
        reg_write = 1'b1;
      end
      op_or: begin
        alu_op    = alu_or;
        reg_write = 1'b1;
      end
      op_addi: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        dest      = rt;
      end
      op_lw: begin
        mem_op    = mem_load;
        reg_write = 1'b1;
        use_imm   = 1'b1;
        dest      = rt;
      end
      op_sw: begin
        mem_op  = mem_store;
        use_imm = 1'b1;
      end
      // nop and anything undefined
      default: ;
    endcase
  end

  register_file u_register_file (
    .clk         (clk),
    .reset       (reset),
    .read_addr_a (rs),
    .read_addr_b (rt),
    .write_en    (wb_valid),
    .write_addr  (wb_reg),
    .write_data  (wb_data),
    .read_a      (read_a),
    .read_b      (read_b)
  );

  ////////////////////////////////////////
  // id/ex register

  always_ff @(posedge clk) begin
    if (reset) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= ir_valid;
    end
  end

  always_ff @(posedge clk) begin
    ex.alu_op    <= alu_op;
    ex.mem_op    <= mem_op;
    ex.reg_write <= reg_write;
    ex.use_imm   <= use_imm;
    ex.rs        <= rs;
    ex.rt        <= rt;
    ex.dest      <= dest;
    ex.read_a    <= read_a;
    ex.read_b    <= read_b;
    ex.imm       <= imm;
  end

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     wb_valid,
  input  reg_idx_t wb_reg,
  input  word_t    wb_data,
  ex_bus.sink      ex,
  mem_bus.source   mem
);

  logic     mem_fwd_ok;
  logic     wb_fwd_ok;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  word_t    opnd_a;
  word_t    opnd_b;
  word_t    alu_in_b;
  word_t    alu_result;

  // the memory stage holds the younger result, so it wins
  function automatic fwd_sel_t select_fwd(input reg_idx_t src);
    if (mem_fwd_ok && mem.dest == src) begin
      return fwd_mem;
    end else if (wb_fwd_ok && wb_reg == src) begin
      return fwd_wb;
    end
    return fwd_reg;
  endfunction

  function automatic word_t pick_operand(input fwd_sel_t sel, input word_t reg_value);
    case (sel)
      fwd_mem: return mem.mem_result;
      fwd_wb:  return wb_data;
      default: return reg_value;
    endcase
  endfunction

  assign mem_fwd_ok = mem.valid && mem.reg_write && (mem.dest != '0);
  assign wb_fwd_ok  = wb_valid && (wb_reg != '0);

  always_comb begin
    fwd_a  = select_fwd(ex.rs);
    fwd_b  = select_fwd(ex.rt);
    opnd_a = pick_operand(fwd_a, ex.read_a);
    opnd_b = pick_operand(fwd_b, ex.read_b);
  end

  // immediate is zero extended
  assign alu_in_b = ex.use_imm ? {{($bits(word_t) - imm_width){1'b0}}, ex.imm} : opnd_b;

  always_comb begin
    case (ex.alu_op)
      alu_sub: alu_result = opnd_a - alu_in_b;
      alu_and: alu_result = opnd_a & alu_in_b;
      alu_or:  alu_result = opnd_a | alu_in_b;
      default: alu_result = opnd_a + alu_in_b;
    endcase
  end

  ////////////////////////////////////////
  // ex/mem register

  always_ff @(posedge clk) begin
    if (reset) begin
      mem.valid <= 1'b0;
    end else begin
      mem.valid <= ex.valid;
    end
  end

  always_ff @(posedge clk) begin
    mem.mem_op     <= ex.mem_op;
    mem.reg_write  <= ex.reg_write;
    mem.dest       <= ex.dest;
    mem.alu_result <= alu_result;
    mem.store_data <= opnd_b;
  end

endmodule

`default_nettype wire

// ==== verilog/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  mem_bus.sink     mem,
  output logic     wb_valid,
  output reg_idx_t wb_reg,
  output word_t    wb_data
);

  word_t     ram [ram_words];
  ram_addr_t addr;

  // word index wraps at the memory size
  assign addr = mem.alu_result[$bits(ram_addr_t)-1:0];

  always_ff @(posedge clk) begin
    if (mem.valid && mem.mem_op == mem_store) begin
      ram[addr] <= mem.store_data;
    end
  end

  // async read, also fed back to execute
  assign mem.mem_result = (mem.mem_op == mem_load) ? ram[addr] : mem.alu_result;

  ////////////////////////////////////////
  // mem/wb register

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= mem.valid && mem.reg_write && (mem.dest != '0);
    end
  end

  always_ff @(posedge clk) begin
    wb_reg  <= mem.dest;
    wb_data <= mem.mem_result;
  end

endmodule

`default_nettype wire

// ==== verilog/pipe_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decode to execute
interface ex_bus import cpu_pkg::*; ();
  logic     valid;
  alu_op_t  alu_op;
  mem_op_t  mem_op;
  logic     reg_write;
  logic     use_imm;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t dest;
  word_t    read_a;
  word_t    read_b;
  imm_t     imm;

  modport source (output valid, alu_op, mem_op, reg_write, use_imm, rs, rt, dest,
                  read_a, read_b, imm);
  modport sink (input valid, alu_op, mem_op, reg_write, use_imm, rs, rt, dest,
                read_a, read_b, imm);
endinterface

// execute to memory, with the memory stage result coming back for forwarding
interface mem_bus import cpu_pkg::*; ();
  logic     valid;
  mem_op_t  mem_op;
  logic     reg_write;
  reg_idx_t dest;
  word_t    alu_result;
  word_t    store_data;
  word_t    mem_result;

  modport source (output valid, mem_op, reg_write, dest, alu_result, store_data,
                  input mem_result);
  modport sink (input valid, mem_op, reg_write, dest, alu_result, store_data,
                output mem_result);
endinterface

`default_nettype wire

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t read_addr_a,
  input  reg_idx_t read_addr_b,
  input  logic     write_en,
  input  reg_idx_t write_addr,
  input  word_t    write_data,
  output word_t    read_a,
  output word_t    read_b
);

  word_t regs [num_regs];
  logic  write_ok;

  // register 0 is never written, so it stays zero from reset
  assign write_ok = write_en && (write_addr != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_ok) begin
      regs[write_addr] <= write_data;
    end
  end

  // same-cycle write shows through
  assign read_a = (write_ok && write_addr == read_addr_a) ? write_data : regs[read_addr_a];
  assign read_b = (write_ok && write_addr == read_addr_b) ? write_data : regs[read_addr_b];

endmodule

`default_nettype wire

// ==== verilog/scalar_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module scalar_pipeline import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     inst_valid,
  input  word_t    inst,
  output logic     wb_valid,
  output reg_idx_t wb_reg,
  output word_t    wb_data
);

  ex_bus  ex_if ();
  mem_bus mem_if ();

  decode_stage u_decode_stage (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data),
    .ex         (ex_if.source)
  );

  execute_stage u_execute_stage (
    .clk      (clk),
    .reset    (reset),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg),
    .wb_data  (wb_data),
    .ex       (ex_if.sink),
    .mem      (mem_if.source)
  );

  // writeback goes out and loops back to decode and execute
  memory_stage u_memory_stage (
    .clk      (clk),
    .reset    (reset),
    .mem      (mem_if.sink),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg),
    .wb_data  (wb_data)
  );

endmodule

`default_nettype wire
